/* logic/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // Beat geometry
    localparam int DATA_BYTES = 4;
    localparam int USER_WID   = 4;

    // Forwarding stages in the bypass lane
    localparam int BYPASS_STAGES = 2;

    // One stream beat, 41 bits
    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] data;
        logic [DATA_BYTES-1:0]      keep;
        logic                       last;
        logic [USER_WID-1:0]        user;
    } beat_t;

    // Holding state of the tlast fold
    // FOLD_EMPTY  nothing held
    // FOLD_HOLD   a beat is held and waits for its release rule
    // FOLD_FLUSH  the held beat is an empty tail already folded, drop it
    typedef enum logic [1:0] {
        FOLD_EMPTY = 2'd0,
        FOLD_HOLD  = 2'd1,
        FOLD_FLUSH = 2'd2
    } fold_state_e;

endpackage : stream_pkg

`default_nettype wire

/* logic/stream_fwd_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fwd_stage (
    input  logic              from_tx,
    input  logic              aresetn,
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    output stream_pkg::beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    logic in_fire;

    // Pull mode
    // Take a new beat when the slot is free or is being drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    // Valid flag of the held beat
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload loads on every open slot, the valid flag qualifies it
    always_ff @(posedge from_tx) begin
        if (in_ready) begin
            out_beat <= in_beat;
        end
    end

endmodule : stream_fwd_stage

`default_nettype wire

/* logic/stream_ready_skid.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_ready_skid (
    input  logic              from_tx,
    input  logic              aresetn,
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    output stream_pkg::beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    import stream_pkg::*;

    logic  out_ready_q;
    logic  ready_falling;
    logic  fwft;
    logic  sample_en;
    beat_t skid_beat;
    logic  skid_valid;

    // Downstream ready, one cycle late
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            out_ready_q <= 1'b0;
        end else begin
            out_ready_q <= out_ready;
        end
    end

    // Empty skid register can always catch one beat (first word fall through)
    assign fwft          = in_valid && !skid_valid && !out_ready_q;
    assign ready_falling = out_ready_q && !out_ready;

    // Catch the beat that was in flight when ready dropped
    assign sample_en = ready_falling || (fwft && !out_ready);

    // Upstream sees only registered ready
    assign in_ready = out_ready_q || fwft;

    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            skid_valid <= 1'b0;
        end else if (skid_valid && out_ready) begin
            skid_valid <= 1'b0;
        end else if (sample_en) begin
            skid_valid <= in_valid;
        end
    end

    // Payload follows the input until a beat is parked
    always_ff @(posedge from_tx) begin
        if (!skid_valid) begin
            skid_beat <= in_beat;
        end
    end

    // Parked beat goes out first, otherwise zero latency passthrough
    always_comb begin
        if (skid_valid) begin
            out_beat  = skid_beat;
            out_valid = 1'b1;
        end else begin
            out_beat  = in_beat;
            out_valid = in_valid;
        end
    end

endmodule : stream_ready_skid

`default_nettype wire

/* logic/stream_tlast_fold.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_tlast_fold (
    input  logic              from_tx,
    input  logic              aresetn,
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    output stream_pkg::beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    import stream_pkg::*;

    fold_state_e state;
    beat_t       hold_beat;
    logic        hold_valid;
    logic        hold_ready;
    logic        tail_empty;
    logic        fold;
    logic        release_ok;

    stream_fwd_stage u_hold (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (hold_beat),
        .out_valid (hold_valid),
        .out_ready (hold_ready)
    );

    // Last beat that carries no bytes, as left behind by packet joining
    assign tail_empty = in_beat.last && (in_beat.keep == '0);

    // Held beat without last meets an empty tail on the input
    assign fold = (state == FOLD_HOLD) && !hold_beat.last && in_valid && tail_empty;

    // A beat without last stays until its successor is visible
    assign release_ok = hold_beat.last || in_valid;

    always_comb begin
        out_beat      = hold_beat;
        out_beat.last = hold_beat.last || fold;
        out_valid     = 1'b0;
        hold_ready    = 1'b0;
        case (state)
            FOLD_HOLD: begin
                out_valid  = release_ok;
                hold_ready = release_ok && out_ready;
            end
            // Swallowed tail drains without an output valid
            FOLD_FLUSH: hold_ready = 1'b1;
            default: ;
        endcase
    end

    // Tail accepted together with the folded beat is marked for flushing
    always_ff @(posedge from_tx) begin
        if (!aresetn) begin
            state <= FOLD_EMPTY;
        end else if (in_valid && in_ready) begin
            state <= fold ? FOLD_FLUSH : FOLD_HOLD;
        end else if (hold_valid && hold_ready) begin
            state <= FOLD_EMPTY;
        end
    end

endmodule : stream_tlast_fold

`default_nettype wire

/* logic/stream_bypass_path.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_bypass_path (
    input  logic              from_tx,
    input  logic              aresetn,
    input  logic              bypass,
    input  stream_pkg::beat_t beat_in,
    input  logic              beat_in_valid,
    output logic              beat_in_ready,
    output stream_pkg::beat_t beat_out,
    output logic              beat_out_valid,
    input  logic              beat_out_ready
);

    import stream_pkg::*;

    // Bypass lane links, index 0 is the lane input
    beat_t stage_beat  [BYPASS_STAGES+1];
    logic  stage_valid [BYPASS_STAGES+1];
    logic  stage_ready [BYPASS_STAGES+1];

    // Processing lane
    logic  fold_in_valid;
    logic  fold_in_ready;
    beat_t fold_beat;
    logic  fold_valid;
    logic  fold_ready;

    // Merged stream into the output skid
    beat_t merge_beat;
    logic  merge_valid;
    logic  merge_ready;

    // Lane split, payload fans out to both lanes
    assign stage_beat[0]  = beat_in;
    assign stage_valid[0] = beat_in_valid && bypass;
    assign fold_in_valid  = beat_in_valid && !bypass;
    assign beat_in_ready  = bypass ? stage_ready[0] : fold_in_ready;

    // Bypass lane, fixed chain of forwarding stages
    generate
        for (genvar i = 0; i < BYPASS_STAGES; i++) begin : g_bypass
            stream_fwd_stage u_bypass_stage (
                .from_tx   (from_tx),
                .aresetn   (aresetn),
                .in_beat   (stage_beat[i]),
                .in_valid  (stage_valid[i]),
                .in_ready  (stage_ready[i]),
                .out_beat  (stage_beat[i+1]),
                .out_valid (stage_valid[i+1]),
                .out_ready (stage_ready[i+1])
            );
        end : g_bypass
    endgenerate

    stream_tlast_fold u_fold (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_beat   (beat_in),
        .in_valid  (fold_in_valid),
        .in_ready  (fold_in_ready),
        .out_beat  (fold_beat),
        .out_valid (fold_valid),
        .out_ready (fold_ready)
    );

    // 2:1 merge on the same select as the split
    assign merge_beat  = bypass ? stage_beat[BYPASS_STAGES] : fold_beat;
    assign merge_valid = bypass ? stage_valid[BYPASS_STAGES] : fold_valid;

    // Ready goes back only to the selected lane
    assign stage_ready[BYPASS_STAGES] = bypass && merge_ready;
    assign fold_ready                 = !bypass && merge_ready;

    // Registers the ready path toward the output port
    stream_ready_skid u_out_skid (
        .from_tx   (from_tx),
        .aresetn   (aresetn),
        .in_beat   (merge_beat),
        .in_valid  (merge_valid),
        .in_ready  (merge_ready),
        .out_beat  (beat_out),
        .out_valid (beat_out_valid),
        .out_ready (beat_out_ready)
    );

endmodule : stream_bypass_path

`default_nettype wire

/* include/stream_tb_cases.svh */
`ifndef STREAM_TB_CASES_SVH
`define STREAM_TB_CASES_SVH

localparam int TB_NUM_CASES = 6;
localparam int TB_NUM_BEATS = 24;
localparam int TB_MAX_BEATS = 6;

// One packet, its beats sit in TB_BEATS from index first on
typedef struct packed {
    logic       bypass;
    logic [7:0] first;
    logic [3:0] count;
    logic [7:0] stall_pct;
} tb_case_t;

localparam tb_case_t TB_CASES [TB_NUM_CASES] = '{
    '{1'b1, 8'd0,  4'd4, 8'd0},
    '{1'b0, 8'd4,  4'd4, 8'd0},
    '{1'b0, 8'd8,  4'd3, 8'd0},
    '{1'b0, 8'd11, 4'd5, 8'd40},
    '{1'b1, 8'd16, 4'd6, 8'd40},
    '{1'b0, 8'd22, 4'd2, 8'd25}
};

// Field order is data, keep, last, user
localparam stream_pkg::beat_t TB_BEATS [TB_NUM_BEATS] = '{
    '{32'h1000_0001, 4'hf, 1'b0, 4'h1},
    '{32'h1000_0002, 4'hf, 1'b0, 4'h1},
    '{32'h1000_0003, 4'h7, 1'b0, 4'h1},
    '{32'h1000_0004, 4'h0, 1'b1, 4'h1},
    '{32'h2000_0001, 4'hf, 1'b0, 4'h2},
    '{32'h2000_0002, 4'hf, 1'b0, 4'h2},
    '{32'h2000_0003, 4'h3, 1'b0, 4'h2},
    '{32'h2000_0004, 4'h0, 1'b1, 4'h2},
    '{32'h3000_0001, 4'hf, 1'b0, 4'h3},
    '{32'h3000_0002, 4'hf, 1'b0, 4'h3},
    '{32'h3000_0003, 4'h1, 1'b1, 4'h3},
    '{32'h4000_0001, 4'hf, 1'b0, 4'h4},
    '{32'h4000_0002, 4'hf, 1'b0, 4'h4},
    '{32'h4000_0003, 4'hf, 1'b0, 4'h5},
    '{32'h4000_0004, 4'hf, 1'b0, 4'h5},
    '{32'h4000_0005, 4'h0, 1'b1, 4'h5},
    '{32'h5000_0001, 4'hf, 1'b0, 4'h6},
    '{32'h5000_0002, 4'hf, 1'b0, 4'h6},
    '{32'h5000_0003, 4'hf, 1'b0, 4'h6},
    '{32'h5000_0004, 4'hf, 1'b0, 4'h6},
    '{32'h5000_0005, 4'hf, 1'b1, 4'h6},
    '{32'h5000_0006, 4'h0, 1'b1, 4'h7},
    '{32'h6000_0001, 4'h3, 1'b0, 4'h8},
    '{32'h6000_0002, 4'h0, 1'b1, 4'h8}
};

`endif

/* tb/tb_stream_bypass_path.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stream_bypass_path;

    import stream_pkg::*;

    `include "stream_tb_cases.svh"

    localparam int CLK_HALF        = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int WATCHDOG_CYCLES = 200 * TB_NUM_CASES;
    localparam int EXP_DEPTH       = 64;

    logic        from_tx;
    logic        aresetn;
    logic        bypass;
    beat_t       beat_in;
    logic        beat_in_valid;
    logic        beat_in_ready;
    beat_t       beat_out;
    logic        beat_out_valid;
    logic        beat_out_ready;

    // Expected beats written by the driver and consumed by the monitor
    beat_t       exp_mem [EXP_DEPTH];
    int          exp_wr;
    int          exp_rd = 0;
    int          mon_errors = 0;
    int          drv_errors;
    int          cycle = 0;
    int          first_acc;
    int          case_base;
    logic        lat_check;
    int unsigned cur_stall;

    stream_bypass_path u_stream_bypass_path (
        .from_tx        (from_tx),
        .aresetn        (aresetn),
        .bypass         (bypass),
        .beat_in        (beat_in),
        .beat_in_valid  (beat_in_valid),
        .beat_in_ready  (beat_in_ready),
        .beat_out       (beat_out),
        .beat_out_valid (beat_out_valid),
        .beat_out_ready (beat_out_ready)
    );

    initial begin
        from_tx = 1'b0;
        forever #CLK_HALF from_tx = ~from_tx;
    end

    always @(posedge from_tx) begin
        cycle <= cycle + 1;
    end

    // Output back-pressure drawn per falling edge
    initial begin
        void'($urandom(32'h05335f3e));
        beat_out_ready = 1'b1;
        forever begin
            @(negedge from_tx);
            if (cur_stall == 0) begin
                beat_out_ready = 1'b1;
            end else begin
                beat_out_ready = (($urandom % 100) >= cur_stall);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge from_tx);
        $display("Timeout after %0d cycles, the output stream never drained", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    function automatic int compare_beat(input beat_t exp_b, input beat_t got_b);
        int n;
        n = 0;
        if (got_b.data !== exp_b.data) begin
            $display("FAIL beat_out.data exp %h got %h", exp_b.data, got_b.data);
            n++;
        end
        if (got_b.keep !== exp_b.keep) begin
            $display("FAIL beat_out.keep exp %h got %h", exp_b.keep, got_b.keep);
            n++;
        end
        if (got_b.last !== exp_b.last) begin
            $display("FAIL beat_out.last exp %h got %h", exp_b.last, got_b.last);
            n++;
        end
        if (got_b.user !== exp_b.user) begin
            $display("FAIL beat_out.user exp %h got %h", exp_b.user, got_b.user);
            n++;
        end
        return n;
    endfunction

    always @(posedge from_tx) begin : monitor
        int mism;
        mism = 0;
        if (aresetn && beat_out_valid && beat_out_ready) begin
            if (exp_rd == exp_wr) begin
                $display("Unexpected extra beat on beat_out, data %h", beat_out.data);
                mism = 1;
            end else begin
                mism = compare_beat(exp_mem[exp_rd], beat_out);
                // First bypass beat must take exactly the stage count
                if (lat_check && exp_rd == case_base && cycle - first_acc != BYPASS_STAGES) begin
                    $display("FAIL beat_out_valid latency exp %h got %h",
                             BYPASS_STAGES, cycle - first_acc);
                    mism++;
                end
                exp_rd <= exp_rd + 1;
            end
        end
        mon_errors <= mon_errors + mism;
    end

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge from_tx);
            if (beat_out_valid !== 1'b0) begin
                $display("FAIL beat_out_valid exp %h got %h", 1'b0, beat_out_valid);
                drv_errors++;
            end
        end
    endtask

    // Reference model folds an empty last beat into the beat before it
    task automatic build_expected(input int c);
        beat_t pkt [TB_MAX_BEATS];
        beat_t b;
        int    n;
        int    k;
        n = 32'(TB_CASES[c].count);
        for (k = 0; k < n; k++) begin
            pkt[k] = TB_BEATS[32'(TB_CASES[c].first) + k];
        end
        k = 0;
        while (k < n) begin
            b = pkt[k];
            if (!TB_CASES[c].bypass && !b.last && k + 1 < n &&
                pkt[k+1].last && pkt[k+1].keep == '0) begin
                b.last = 1'b1;
                k = k + 2;
            end else begin
                k = k + 1;
            end
            exp_mem[exp_wr] = b;
            exp_wr++;
        end
    endtask

    task automatic send_beat(input beat_t b, output int acc_cycle);
        beat_in       = b;
        beat_in_valid = 1'b1;
        @(posedge from_tx);
        while (!beat_in_ready) begin
            @(posedge from_tx);
        end
        acc_cycle = cycle;
        @(negedge from_tx);
    endtask

    task automatic run_case(input int c);
        int          n;
        int          k;
        int          acc;
        int          errs_before;
        fold_state_e fold_st;
        n           = 32'(TB_CASES[c].count);
        errs_before = drv_errors + mon_errors;
        @(posedge from_tx);
        case_base = exp_wr;
        build_expected(c);
        cur_stall = 32'(TB_CASES[c].stall_pct);
        lat_check = TB_CASES[c].bypass && (TB_CASES[c].stall_pct == 8'd0);
        // Lane select changes only while both lanes are empty
        @(negedge from_tx);
        bypass = TB_CASES[c].bypass;
        @(negedge from_tx);
        for (k = 0; k < n; k++) begin
            send_beat(TB_BEATS[32'(TB_CASES[c].first) + k], acc);
            if (k == 0) begin
                first_acc = acc;
            end
        end
        beat_in_valid = 1'b0;
        beat_in       = '0;
        while (exp_rd != exp_wr) begin
            @(posedge from_tx);
        end
        repeat (2) @(posedge from_tx);
        fold_st = u_stream_bypass_path.u_fold.state;
        if (fold_st != FOLD_EMPTY) begin
            $display("Fold lane still busy after the packet drained");
            drv_errors++;
        end
        $display("case %0d %s: %0d beats in, %0d out, fold %s, %0d errors",
                 c, TB_CASES[c].bypass ? "bypass" : "fold", n, exp_rd - case_base,
                 fold_st.name(), drv_errors + mon_errors - errs_before);
    endtask

    initial begin
        int c;
        int total;
        aresetn       = 1'b0;
        bypass        = 1'b0;
        beat_in       = '0;
        beat_in_valid = 1'b0;
        exp_wr        = 0;
        drv_errors    = 0;
        first_acc     = 0;
        case_base     = 0;
        lat_check     = 1'b0;
        cur_stall     = 0;
        // Outputs are unknown until the first reset edge
        @(posedge from_tx);
        check_idle(RESET_CYCLES - 1);
        @(negedge from_tx);
        aresetn = 1'b1;
        check_idle(3);
        $display("reset idle check: %0d errors", drv_errors);
        for (c = 0; c < TB_NUM_CASES; c++) begin
            run_case(c);
        end
        repeat (4) @(posedge from_tx);
        total = drv_errors + mon_errors;
        $display("cases %0d, beats checked %0d, errors %0d", TB_NUM_CASES, exp_rd, total);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_stream_bypass_path

`default_nettype wire

/* build.f */
+incdir+include
logic/stream_pkg.sv
logic/stream_fwd_stage.sv
logic/stream_ready_skid.sv
logic/stream_tlast_fold.sv
logic/stream_bypass_path.sv
tb/tb_stream_bypass_path.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the stream bypass path testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_stream_bypass_path
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported errors, see $LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
